//--- include/simd_consts.svh
/* Sizing constants for the SIMD result-return path.
   Include wherever lane counts, widths or FIFO sizes are needed. */

`ifndef SIMD_CONSTS_SVH
`define SIMD_CONSTS_SVH

// ------------------------------
// Execution lanes
// ------------------------------

// Lanes returning results in parallel
`define SIMD_NUM_LANES            4
// Result word per lane
`define SIMD_LANE_WIDTH           32
// Standard interface control per lane, start and end of stream markers
`define SIMD_CNTL_WIDTH           2

// Operation tag from the PE controller
`define SIMD_TAG_WIDTH            8

// ------------------------------
// FIFO sizing
// ------------------------------

// Lane result FIFOs, ready drops at the threshold to leave room for in-flight writes
`define SIMD_LANE_FIFO_DEPTH      8
`define SIMD_LANE_FIFO_THRESHOLD  6

// Tag FIFO, shallow since only a few operations are outstanding
`define SIMD_TAG_FIFO_DEPTH       4
`define SIMD_TAG_FIFO_THRESHOLD   3

`endif

//--- rtl/simd_pkg.sv
/* Shared types for the SIMD result-return path.
   Import by wildcard in the module header. */

`include "simd_consts.svh"

package simd_pkg;

  // ------------------------------
  // Upstream controller states
  // ------------------------------

  // Wait for tag, lane data and upstream ready, pulse valid for one cycle,
  // then follow complete high and low before the next send
  typedef enum logic [2:0]
  {
    idle_wait,
    send_data,
    wait_complete,
    wait_complete_low,
    done
  } upstream_state_t;

  // ------------------------------
  // Lane and tag payloads
  // ------------------------------

  // One lane result word
  typedef logic [`SIMD_LANE_WIDTH-1:0] lane_data_t;
  // Start/end markers travelling with each lane word
  typedef logic [`SIMD_CNTL_WIDTH-1:0] lane_cntl_t;
  // Operation tag, returned upstream with the lane results
  typedef logic [`SIMD_TAG_WIDTH-1:0]  tag_t;

endpackage

//--- rtl/result_fifo.sv
/* Circular-buffer FIFO with a registered head and an almost-full flag.
   Built once per lane for results and once for operation tags. */

`timescale 1ns/1ps

module result_fifo
#(
  parameter int DEPTH     = 8,
  parameter int THRESHOLD = 6,
  parameter int WIDTH     = 32
)
(
  input  logic             clk,
  input  logic             arst_n,
  input  logic             write,
  input  logic [WIDTH-1:0] write_data,
  input  logic             pipe_read,
  output logic             pipe_valid,
  output logic [WIDTH-1:0] pipe_data,
  output logic             almost_full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // ------------------------------
  // Storage and pointers
  // ------------------------------

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // Occupancy includes the entry currently shown at the head
  logic [CNT_W-1:0] count;

  logic push;
  logic pop;
  logic load_head;

  // Writes into a full buffer are dropped
  assign push      = write && (count != CNT_W'(DEPTH));
  // Head leaves only when it is valid and the consumer reads it
  assign pop       = pipe_read && pipe_valid;
  // Refill the head register the cycle after it empties
  assign load_head = !pipe_valid && (count != '0);

  assign almost_full = (count >= CNT_W'(THRESHOLD));

  // Payload storage
  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wr_ptr] <= write_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      // Entry stays in the buffer until popped so the full check stays exact
      if (pop)
      begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop)
      begin
        count <= count + 1'b1;
      end
      else if (pop && !push)
      begin
        count <= count - 1'b1;
      end
    end
  end

  // ------------------------------
  // Registered head
  // ------------------------------

  // Flopped output keeps the wide upstream fan-out off the memory read path
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pipe_valid <= 1'b0;
    end
    else if (pop)
    begin
      pipe_valid <= 1'b0;
    end
    else if (load_head)
    begin
      pipe_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (load_head)
    begin
      pipe_data <= mem[rd_ptr];
    end
  end

endmodule

//--- rtl/upstream_cntl.sv
/* Upstream send controller for the SIMD result-return path.
   Pulses valid and pops every FIFO once tag, lane data and upstream ready line up. */

`timescale 1ns/1ps

`include "simd_consts.svh"

module upstream_cntl
  import simd_pkg::*;
(
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       tag_valid,
  input  logic [`SIMD_NUM_LANES-1:0] lane_valids,
  input  logic                       sui_regs_ready,
  input  logic                       sui_regs_complete,
  output logic                       fifo_read,
  output logic [`SIMD_NUM_LANES-1:0] regs_valid
);

  // ------------------------------
  // Upstream input registers
  // ------------------------------

  // Both levels come from the stack interface, flopped once before use
  logic ready_d1;
  logic complete_d1;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ready_d1    <= 1'b0;
      complete_d1 <= 1'b0;
    end
    else
    begin
      ready_d1    <= sui_regs_ready;
      complete_d1 <= sui_regs_complete;
    end
  end

  // ------------------------------
  // Send FSM
  // ------------------------------

  upstream_state_t state_q;
  upstream_state_t state_d;
  logic            send_ok;
  logic            sending;

  // A full set means the oldest tag plus the oldest entry of every lane
  assign send_ok = tag_valid && (&lane_valids) && ready_d1;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_q <= idle_wait;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      idle_wait:
      begin
        if (send_ok)
        begin
          state_d = send_data;
        end
      end
      // Single cycle, the pulse itself
      send_data:         state_d = wait_complete;
      // Upstream raises complete once the packet has gone out
      wait_complete:
      begin
        if (complete_d1)
        begin
          state_d = wait_complete_low;
        end
      end
      // Hold off until complete drops so one complete is never counted twice
      wait_complete_low:
      begin
        if (!complete_d1)
        begin
          state_d = done;
        end
      end
      done:              state_d = idle_wait;
      default:           state_d = idle_wait;
    endcase
  end

  // Pop and upstream valid are the same pulse
  assign sending    = (state_q == send_data);
  assign fifo_read  = sending;
  assign regs_valid = {`SIMD_NUM_LANES{sending}};

endmodule

//--- rtl/simd_result_return.sv
/* Result-return path of the PE SIMD wrapper.
   Queues lane results and operation tags, then hands them to the stack upstream interface. */

`timescale 1ns/1ps

`include "simd_consts.svh"

module simd_result_return
  import simd_pkg::*;
(
  input  logic                       clk,
  input  logic                       arst_n,

  // Lane results from the streaming operations
  input  logic [`SIMD_NUM_LANES-1:0] scntl_reg_valid,
  input  lane_cntl_t                 scntl_reg_cntl [`SIMD_NUM_LANES],
  input  lane_data_t                 scntl_reg_data [`SIMD_NUM_LANES],
  output logic [`SIMD_NUM_LANES-1:0] reg_scntl_ready,

  // Operation tags from the PE controller
  input  logic                       cntl_simd_tag_valid,
  input  tag_t                       cntl_simd_tag,
  output logic                       simd_cntl_tag_ready,

  // Stack upstream interface
  output logic [`SIMD_NUM_LANES-1:0] simd_sui_regs_valid,
  output tag_t                       simd_sui_tag,
  output lane_cntl_t                 simd_sui_regs_cntl [`SIMD_NUM_LANES],
  output lane_data_t                 simd_sui_regs [`SIMD_NUM_LANES],
  input  logic                       sui_simd_regs_ready,
  input  logic                       sui_simd_regs_complete
);

  localparam int LANE_ENTRY_W = `SIMD_CNTL_WIDTH + `SIMD_LANE_WIDTH;

  // Head status of every FIFO, gathered for the controller
  logic [`SIMD_NUM_LANES-1:0] lane_valid;
  logic [`SIMD_NUM_LANES-1:0] lane_almost_full;
  logic                       tag_valid;
  logic                       tag_almost_full;
  // One pop shared by all FIFOs so lanes and tag stay aligned
  logic                       pipe_read;

  // ------------------------------
  // Lane result FIFOs
  // ------------------------------

  for (genvar gi = 0; gi < `SIMD_NUM_LANES; gi++)
  begin : g_lane_fifo
    // Control field rides in the upper bits of each entry
    logic [LANE_ENTRY_W-1:0] lane_head;

    result_fifo
    #(
      .DEPTH     (`SIMD_LANE_FIFO_DEPTH),
      .THRESHOLD (`SIMD_LANE_FIFO_THRESHOLD),
      .WIDTH     (LANE_ENTRY_W)
    )
    u_lane_fifo
    (
      .clk         (clk),
      .arst_n      (arst_n),
      .write       (scntl_reg_valid[gi]),
      .write_data  ({scntl_reg_cntl[gi], scntl_reg_data[gi]}),
      .pipe_read   (pipe_read),
      .pipe_valid  (lane_valid[gi]),
      .pipe_data   (lane_head),
      .almost_full (lane_almost_full[gi])
    );

    assign simd_sui_regs_cntl[gi] = lane_head[LANE_ENTRY_W-1 -: `SIMD_CNTL_WIDTH];
    assign simd_sui_regs[gi]      = lane_head[`SIMD_LANE_WIDTH-1:0];
  end

  // Lane ready follows the count straight away
  assign reg_scntl_ready = ~lane_almost_full;

  // ------------------------------
  // Tag FIFO
  // ------------------------------

  result_fifo
  #(
    .DEPTH     (`SIMD_TAG_FIFO_DEPTH),
    .THRESHOLD (`SIMD_TAG_FIFO_THRESHOLD),
    .WIDTH     (`SIMD_TAG_WIDTH)
  )
  u_tag_fifo
  (
    .clk         (clk),
    .arst_n      (arst_n),
    .write       (cntl_simd_tag_valid),
    .write_data  (cntl_simd_tag),
    .pipe_read   (pipe_read),
    .pipe_valid  (tag_valid),
    .pipe_data   (simd_sui_tag),
    .almost_full (tag_almost_full)
  );

  // Tag ready is flopped, one cycle behind the tag count
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      simd_cntl_tag_ready <= 1'b0;
    end
    else
    begin
      simd_cntl_tag_ready <= ~tag_almost_full;
    end
  end

  // ------------------------------
  // Upstream controller
  // ------------------------------

  upstream_cntl u_upstream_cntl
  (
    .clk               (clk),
    .arst_n            (arst_n),
    .tag_valid         (tag_valid),
    .lane_valids       (lane_valid),
    .sui_regs_ready    (sui_simd_regs_ready),
    .sui_regs_complete (sui_simd_regs_complete),
    .fifo_read         (pipe_read),
    .regs_valid        (simd_sui_regs_valid)
  );

endmodule

//--- tests/simd_result_return_assertions.sv
/* Protocol assertions on the result-return top level.
   Attached to simd_result_return by bind from the testbench. */

`timescale 1ns/1ps

`include "simd_consts.svh"

module simd_result_return_assertions
(
  input logic                       clk,
  input logic                       arst_n,
  input logic [`SIMD_NUM_LANES-1:0] simd_sui_regs_valid,
  input logic                       sui_simd_regs_complete,
  input logic [`SIMD_NUM_LANES-1:0] scntl_reg_valid,
  input logic [`SIMD_NUM_LANES-1:0] reg_scntl_ready
);

  // ------------------------------
  // Upstream valid
  // ------------------------------

  // Send state lasts exactly one cycle
  valid_single_cycle: assert property (@(posedge clk) disable iff (!arst_n)
    simd_sui_regs_valid[0] |=> !simd_sui_regs_valid[0])
    else $error("upstream valid held for more than one cycle");

  // One pulse drives every lane bit
  valid_bits_equal: assert property (@(posedge clk) disable iff (!arst_n)
    (simd_sui_regs_valid == '0) || (&simd_sui_regs_valid))
    else $error("upstream valid bits differ between lanes");

  // Next send only after complete has dropped
  valid_not_in_complete: assert property (@(posedge clk) disable iff (!arst_n)
    !(simd_sui_regs_valid[0] && sui_simd_regs_complete))
    else $error("upstream valid while complete is high");

  // Producer side, a write needs that lane's ready
  write_needs_ready: assert property (@(posedge clk) disable iff (!arst_n)
    (scntl_reg_valid & ~reg_scntl_ready) == '0)
    else $error("lane write while lane ready is low");

endmodule

//--- tests/tb_simd_result_return.sv
/* Testbench for the SIMD result-return path.
   Runs the command script from the tests data file against queue models and an upstream responder. */

`timescale 1ns/1ps

`include "simd_consts.svh"

module tb_simd_result_return
  import simd_pkg::*;
();

  localparam int NL         = `SIMD_NUM_LANES;
  localparam int SCRIPT_LEN = 64;

  logic          clk;
  logic          arst_n;
  logic [NL-1:0] scntl_reg_valid;
  lane_cntl_t    scntl_reg_cntl [NL];
  lane_data_t    scntl_reg_data [NL];
  logic [NL-1:0] reg_scntl_ready;
  logic          cntl_simd_tag_valid;
  tag_t          cntl_simd_tag;
  logic          simd_cntl_tag_ready;
  logic [NL-1:0] simd_sui_regs_valid;
  tag_t          simd_sui_tag;
  lane_cntl_t    simd_sui_regs_cntl [NL];
  lane_data_t    simd_sui_regs [NL];
  logic          sui_simd_regs_ready;
  logic          sui_simd_regs_complete;

  // Script, reference queues and model counts
  logic [47:0]   script [SCRIPT_LEN];
  logic [33:0]   lane_q [NL][$];
  tag_t          tag_q [$];
  int            lane_cnt [NL];
  int            tag_cnt;
  logic [NL-1:0] lane_push_pend;
  logic          tag_push_pend;
  logic          pop_pend;
  logic          tag_ready_exp;
  logic          ready_low_pend;
  int            ready_low_cnt;
  logic [31:0]   lcg_state;
  int            cycle_cnt;
  int            cycle_limit;
  // Upstream responder
  logic          resp_busy;
  int            resp_timer;

  simd_result_return dut (.*);

  bind simd_result_return simd_result_return_assertions u_assertions
  (
    .clk                    (clk),
    .arst_n                 (arst_n),
    .simd_sui_regs_valid    (simd_sui_regs_valid),
    .sui_simd_regs_complete (sui_simd_regs_complete),
    .scntl_reg_valid        (scntl_reg_valid),
    .reg_scntl_ready        (reg_scntl_ready)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // ------------------------------
  // Helpers
  // ------------------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
    begin
      $display("ERROR: time %0t signal %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
      fail_run("Value mismatch, run stopped");
    end
  endtask

  // Oldest tag and lane entries must sit at the FIFO heads
  task automatic check_pulse();
    logic [33:0] entry;
    if (resp_busy)
      fail_run("Valid pulse before the previous complete handshake ended");
    if (ready_low_cnt >= 2)
      fail_run("Valid pulse while upstream ready was low");
    if (tag_q.size() == 0)
      fail_run("Valid pulse with no tag queued");
    compare("simd_sui_regs_valid", 32'({NL{1'b1}}), 32'(simd_sui_regs_valid));
    compare("simd_sui_tag", 32'(tag_q.pop_front()), 32'(simd_sui_tag));
    for (int l = 0; l < NL; l++)
    begin
      if (lane_q[l].size() == 0)
        fail_run($sformatf("Valid pulse with lane %0d empty", l));
      entry = lane_q[l].pop_front();
      compare($sformatf("simd_sui_regs_cntl[%0d]", l), 32'(entry[33:32]),
              32'(simd_sui_regs_cntl[l]));
      compare($sformatf("simd_sui_regs[%0d]", l), entry[31:0], simd_sui_regs[l]);
    end
    pop_pend   = 1'b1;
    resp_busy  = 1'b1;
    resp_timer = 0;
  endtask

  // Advance one clock, model the edge just passed and check at the falling edge
  task automatic step_cycle();
    lane_push_pend = scntl_reg_valid;
    tag_push_pend  = cntl_simd_tag_valid;
    ready_low_pend = !sui_simd_regs_ready;
    @(negedge clk);
    scntl_reg_valid     = '0;
    cntl_simd_tag_valid = 1'b0;
    cycle_cnt++;
    if (cycle_cnt > cycle_limit)
      fail_run("Timeout, the DUT stopped making progress within the cycle limit");
    // Tag ready is flopped so it sees the count from one edge earlier
    tag_ready_exp = (tag_cnt < `SIMD_TAG_FIFO_THRESHOLD);
    tag_cnt       = tag_cnt + int'(tag_push_pend) - int'(pop_pend);
    for (int l = 0; l < NL; l++)
    begin
      lane_cnt[l] = lane_cnt[l] + int'(lane_push_pend[l]) - int'(pop_pend);
      compare($sformatf("reg_scntl_ready[%0d]", l),
              32'(lane_cnt[l] < `SIMD_LANE_FIFO_THRESHOLD), 32'(reg_scntl_ready[l]));
    end
    compare("simd_cntl_tag_ready", 32'(tag_ready_exp), 32'(simd_cntl_tag_ready));
    pop_pend      = 1'b0;
    ready_low_cnt = ready_low_pend ? ready_low_cnt + 1 : 0;
    // Upstream responder drives complete high from two to four cycles after the pulse
    if (resp_busy)
    begin
      resp_timer++;
      sui_simd_regs_complete = (resp_timer >= 2) && (resp_timer <= 4);
      if (resp_timer == 5)
      begin
        resp_busy = 1'b0;
      end
    end
    if (simd_sui_regs_valid != '0)
      check_pulse();
  endtask

  task automatic run_command(input logic [47:0] cmd);
    logic [3:0]    op;
    logic [NL-1:0] pend;
    logic [7:0]    field;
    logic [31:0]   value;
    op    = cmd[47:44];
    pend  = cmd[43:40];
    field = cmd[39:32];
    value = cmd[31:0];
    case (op)
      // Lane writes go out per lane as soon as that lane's ready allows
      4'h1, 4'h2:
      begin
        while (pend != '0)
        begin
          for (int l = 0; l < NL; l++)
          begin
            if (pend[l] && reg_scntl_ready[l])
            begin
              lcg_state          = lcg_next(lcg_state);
              scntl_reg_data[l]  = (op == 4'h2) ? lcg_state : value + 32'(l);
              scntl_reg_cntl[l]  = field[1:0];
              scntl_reg_valid[l] = 1'b1;
              lane_q[l].push_back({field[1:0], scntl_reg_data[l]});
              pend[l] = 1'b0;
            end
          end
          step_cycle();
        end
      end
      4'h3:
      begin
        while (!simd_cntl_tag_ready)
          step_cycle();
        cntl_simd_tag       = field;
        cntl_simd_tag_valid = 1'b1;
        tag_q.push_back(field);
        step_cycle();
      end
      4'h4:    sui_simd_regs_ready = value[0];
      4'h5:    repeat (value) step_cycle();
      default: fail_run($sformatf("Unknown script opcode %0h", op));
    endcase
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial
  begin
    int n_cmds;
    int idle_sum;
    arst_n                 = 1'b0;
    scntl_reg_valid        = '0;
    cntl_simd_tag_valid    = 1'b0;
    cntl_simd_tag          = '0;
    sui_simd_regs_ready    = 1'b0;
    sui_simd_regs_complete = 1'b0;
    for (int l = 0; l < NL; l++)
    begin
      scntl_reg_cntl[l] = '0;
      scntl_reg_data[l] = '0;
      lane_cnt[l]       = 0;
    end
    tag_cnt       = 0;
    pop_pend      = 1'b0;
    ready_low_cnt = 0;
    lcg_state     = 32'd35067;
    cycle_cnt     = 0;
    resp_busy     = 1'b0;
    resp_timer    = 0;
    for (int i = 0; i < SCRIPT_LEN; i++)
      script[i] = '0;
    $readmemh("tests/simd_result_return_tests.dat", script);
    // Limit grows with command count and scripted idle time
    n_cmds   = 0;
    idle_sum = 0;
    while (n_cmds < SCRIPT_LEN && script[n_cmds][47:44] != 4'h0)
    begin
      if (script[n_cmds][47:44] == 4'h5)
        idle_sum += int'(script[n_cmds][31:0]);
      n_cmds++;
    end
    cycle_limit = 200 + 4 * (16 * n_cmds + idle_sum);
    if (n_cmds == 0)
      fail_run("Stimulus script is empty or could not be read");
    repeat (4) @(posedge clk);
    @(negedge clk);
    compare("simd_sui_regs_valid", 32'(0), 32'(simd_sui_regs_valid));
    compare("reg_scntl_ready", 32'({NL{1'b1}}), 32'(reg_scntl_ready));
    compare("simd_cntl_tag_ready", 32'(0), 32'(simd_cntl_tag_ready));
    arst_n = 1'b1;
    for (int i = 0; i < n_cmds; i++)
      run_command(script[i]);
    // Drain whatever is still queued
    while (tag_q.size() != 0 || resp_busy || lane_q[0].size() != 0)
      step_cycle();
    repeat (4) step_cycle();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- tests/simd_result_return_tests.dat
// Command script, one 48-bit hex word per line
// [47:44] op [43:40] lane mask [39:32] tag or lane cntl [31:0] data or idle cycles
// op 1 lane data+lane index, 2 lane LCG data, 3 tag, 4 upstream ready, 5 idle, 0 end
400000000001
500000000004
// Lane data waits for its tag
1F01A5A50000
50000000000A
303C00000000
500000000010
// Tag waits for the last lane
304100000000
170212340000
50000000000A
180312340000
500000000010
// Upstream ready low, lanes and tags fill to their thresholds
400000000000
2F0100000000
2F0000000000
2F0000000000
2F0200000000
2F0000000000
2F0300000000
307000000000
307100000000
307200000000
500000000014
// Ready back high, drain
400000000001
500000000028
307300000000
307400000000
307500000000
500000000028
// Mixed lane groups
2F0100000000
305000000000
1503CAFE0000
1A00BEEF0000
305100000000
500000000020
000000000000

//--- flist.f
+incdir+include
rtl/simd_pkg.sv
rtl/result_fifo.sv
rtl/upstream_cntl.sv
rtl/simd_result_return.sv
tests/simd_result_return_assertions.sv
tests/tb_simd_result_return.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_simd_result_return
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

# Build, run, then fail if the log holds the fail message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
